//--- all.f
+incdir+common
common/excp_pkg.sv
excp/excp_alu_decode.sv
excp/excp_irq_detect.sv
excp/excp_wfi_ctrl.sv
excp/excp_trap_arbiter.sv
excp/excp_csr_update.sv
verilog/exu_excp_top.sv
dv/excp_tb_clock.sv
dv/excp_tb.sv

//--- dv/excp_tb.sv
/*
  Testbench for the commit-stage trap unit
  Drives random traps, interrupts and a WFI sequence and checks against excp_ref
*/
`timescale 1ns/1ns

module excp_tb import excp_pkg::*; ();

  typedef struct packed {
    logic  flush;
    logic  taken;
    logic  alu_ready;
    logic  longp_ready;
    logic  active;
    xlen_t cause;
    pc_t   epc;
    addr_t badaddr;
  } exp_t;

  logic  clk, reset;
  logic  commit_trap, core_wfi, wfi_halt_ifu_req, wfi_halt_exu_req;
  logic  wfi_halt_ifu_ack, wfi_halt_exu_ack, amo_wait;
  logic  alu_excp_i_ready, alu_excp_i_valid, alu_excp_i_ld, alu_excp_i_stamo;
  logic  alu_excp_i_misalgn, alu_excp_i_buserr, alu_excp_i_ecall, alu_excp_i_ebreak;
  logic  alu_excp_i_wfi, alu_excp_i_ifu_misalgn, alu_excp_i_ifu_buserr;
  logic  alu_excp_i_ifu_ilegl, alu_excp_i_pc_vld;
  addr_t alu_excp_i_badaddr;
  pc_t   alu_excp_i_pc;
  xlen_t alu_excp_i_instr;
  logic  longp_excp_i_ready, longp_excp_i_valid, longp_excp_i_ld, longp_excp_i_st;
  logic  longp_excp_i_buserr, longp_excp_i_insterr;
  addr_t longp_excp_i_badaddr;
  pc_t   longp_excp_i_pc;
  logic  excpirq_flush_ack, excpirq_flush_req;
  pc_t   excpirq_flush_add_op1, excpirq_flush_add_op2;
  xlen_t csr_mtvec_r;
  logic  cmt_ena;
  addr_t cmt_badaddr;
  pc_t   cmt_epc;
  xlen_t cmt_cause;
  logic  cmt_badaddr_ena, cmt_epc_ena, cmt_cause_ena, cmt_status_ena;
  logic  ext_irq_r, sft_irq_r, tmr_irq_r, status_mie_r, mtie_r, msie_r, meie_r;
  logic  oitf_empty, excp_active;

  int          errors;
  int          checks;
  int          tests;
  int          k;
  int          n;
  int          err_mark;
  bit          chk_en;
  // Expected WFI state is sleep
  bit          sleeping;

  excp_tb_clock i_clock (.clk(clk), .reset(reset));

  exu_excp_top i_exu_excp_top (.*);

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic exp_t excp_ref();
    exp_t        e;
    logic        fault, irq, wfi_irq, lp_f, irq_f, alu_f;
    logic [4:0]  code;
    addr_t       abad;
    e = '0;
    fault = alu_excp_i_misalgn | alu_excp_i_buserr | alu_excp_i_ecall | alu_excp_i_ebreak
          | alu_excp_i_ifu_misalgn | alu_excp_i_ifu_buserr | alu_excp_i_ifu_ilegl;
    // ALU cause with the fetch side first
    if (alu_excp_i_ifu_misalgn) code = 5'd0;
    else if (alu_excp_i_ifu_buserr) code = 5'd1;
    else if (alu_excp_i_ifu_ilegl) code = 5'd2;
    else if (alu_excp_i_ebreak) code = 5'd3;
    else if (alu_excp_i_ld & alu_excp_i_misalgn) code = 5'd4;
    else if (alu_excp_i_ld & alu_excp_i_buserr) code = 5'd5;
    else if (alu_excp_i_stamo & alu_excp_i_misalgn) code = 5'd6;
    else if (alu_excp_i_stamo & alu_excp_i_buserr) code = 5'd7;
    else if (alu_excp_i_ecall) code = 5'd11;
    else code = 5'd31;
    // Pc for fetch faults and ebreak, instruction for illegal, address for data faults
    case (code)
      5'd0, 5'd1, 5'd3:       abad = alu_excp_i_pc;
      5'd2:                   abad = alu_excp_i_instr;
      5'd4, 5'd5, 5'd6, 5'd7: abad = alu_excp_i_badaddr;
      default:                abad = '0;
    endcase
    wfi_irq = (sft_irq_r & msie_r) | (tmr_irq_r & mtie_r) | (ext_irq_r & meie_r);
    irq     = wfi_irq & status_mie_r & ~amo_wait;
    // Long-pipe, then interrupt, then ALU
    lp_f  = longp_excp_i_valid;
    irq_f = irq & oitf_empty & alu_excp_i_pc_vld & ~lp_f;
    alu_f = alu_excp_i_valid & fault & oitf_empty & ~irq & ~lp_f;
    e.flush       = lp_f | irq_f | alu_f;
    e.taken       = e.flush & excpirq_flush_ack;
    e.longp_ready = excpirq_flush_ack;
    e.alu_ready   = fault ? (excpirq_flush_ack & oitf_empty & ~irq & ~lp_f) : (~irq & ~lp_f);
    // Clock gate wakeup follows the unmasked interrupts only while asleep
    e.active      = sleeping ? wfi_irq : irq;
    if (lp_f) begin
      if (longp_excp_i_ld & longp_excp_i_buserr) e.cause = 32'd5;
      else if (longp_excp_i_st & longp_excp_i_buserr) e.cause = 32'd7;
      else if (longp_excp_i_insterr) e.cause = 32'd16;
      else e.cause = 32'd31;
      e.epc = longp_excp_i_pc;
      if (longp_excp_i_buserr & (longp_excp_i_ld | longp_excp_i_st)) begin
        e.badaddr = longp_excp_i_badaddr;
      end
    end else if (irq_f) begin
      // Software over timer over external
      if (sft_irq_r & msie_r) e.cause = 32'h8000_0003;
      else if (tmr_irq_r & mtie_r) e.cause = 32'h8000_0007;
      else e.cause = 32'h8000_000b;
      e.epc = alu_excp_i_pc;
    end else begin
      e.cause   = 32'(code);
      e.epc     = alu_excp_i_pc;
      e.badaddr = abad;
    end
    return e;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  // Compare in the middle of the cycle after the inputs have settled
  always @(negedge clk) begin : compare_outputs
    exp_t e;
    if (chk_en) begin
      e = excp_ref();
      check_val("excpirq_flush_req", excpirq_flush_req, e.flush);
      check_val("commit_trap", commit_trap, e.taken);
      check_val("csr enables", {cmt_cause_ena, cmt_epc_ena, cmt_status_ena, cmt_badaddr_ena},
                {4{e.taken}});
      check_val("alu_excp_i_ready", alu_excp_i_ready, e.alu_ready);
      check_val("longp_excp_i_ready", longp_excp_i_ready, e.longp_ready);
      check_val("excp_active", excp_active, e.active);
      check_val("flush op1", excpirq_flush_add_op1, csr_mtvec_r);
      check_val("flush op2", excpirq_flush_add_op2, 32'h0);
      if (e.flush) begin
        check_val("cmt_cause", cmt_cause, e.cause);
        check_val("cmt_epc", cmt_epc, e.epc);
        check_val("cmt_badaddr", cmt_badaddr, e.badaddr);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_inputs();
    {wfi_halt_ifu_ack, wfi_halt_exu_ack, amo_wait, cmt_ena} = '0;
    {alu_excp_i_valid, alu_excp_i_ld, alu_excp_i_stamo, alu_excp_i_misalgn} = '0;
    {alu_excp_i_buserr, alu_excp_i_ecall, alu_excp_i_ebreak, alu_excp_i_wfi} = '0;
    {alu_excp_i_ifu_misalgn, alu_excp_i_ifu_buserr, alu_excp_i_ifu_ilegl} = '0;
    {alu_excp_i_pc_vld, longp_excp_i_valid, longp_excp_i_ld, longp_excp_i_st} = '0;
    {longp_excp_i_buserr, longp_excp_i_insterr, excpirq_flush_ack} = '0;
    {ext_irq_r, sft_irq_r, tmr_irq_r, status_mie_r, mtie_r, msie_r, meie_r} = '0;
    alu_excp_i_badaddr   = 32'h1000_0040;
    alu_excp_i_pc        = 32'h8000_0100;
    alu_excp_i_instr     = 32'h0000_0013;
    longp_excp_i_badaddr = 32'h2000_0080;
    longp_excp_i_pc      = 32'h8000_0200;
    csr_mtvec_r          = 32'h8000_0000;
    oitf_empty           = 1'b1;
  endtask

  // Index 0..8 sets one fault and higher values leave the commit clean
  task automatic set_alu_fault(input int idx);
    case (idx)
      0: alu_excp_i_ifu_misalgn = 1'b1;
      1: alu_excp_i_ifu_buserr = 1'b1;
      2: alu_excp_i_ifu_ilegl = 1'b1;
      3: alu_excp_i_ebreak = 1'b1;
      4: {alu_excp_i_ld, alu_excp_i_misalgn} = 2'b11;
      5: {alu_excp_i_ld, alu_excp_i_buserr} = 2'b11;
      6: {alu_excp_i_stamo, alu_excp_i_misalgn} = 2'b11;
      7: {alu_excp_i_stamo, alu_excp_i_buserr} = 2'b11;
      8: alu_excp_i_ecall = 1'b1;
      default: ;
    endcase
    alu_excp_i_pc      = $urandom;
    alu_excp_i_instr   = $urandom;
    alu_excp_i_badaddr = $urandom;
    csr_mtvec_r        = $urandom;
  endtask

  task automatic random_irq();
    {sft_irq_r, tmr_irq_r, ext_irq_r} = 3'($urandom);
    {msie_r, mtie_r, meie_r} = 3'($urandom);
    status_mie_r = ($urandom_range(3, 0) != 0);
    amo_wait     = ($urandom_range(3, 0) == 0);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-10s %s (%0d errors)", name,
             (errors == err_mark) ? "done" : "failed", errors - err_mark);
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    errors   = 0;
    checks   = 0;
    tests    = 0;
    err_mark = 0;
    chk_en   = 1'b0;
    sleeping = 1'b0;
    void'($urandom(32'heb90_7bb9));
    clear_inputs();

    // Reset
    n = 0;
    while (reset !== 1'b0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    assert (reset === 1'b0) else timed_out("reset never deasserted");
    #1;
    chk_en = 1'b1;
    check_val("wfi halt requests", {wfi_halt_ifu_req, wfi_halt_exu_req}, 2'b00);
    check_val("core_wfi", core_wfi, 1'b0);
    next_cycle();
    end_test("reset");

    // ALU exceptions with a single fault each
    repeat (40) begin
      clear_inputs();
      set_alu_fault($urandom_range(8, 0));
      {alu_excp_i_valid, alu_excp_i_pc_vld, excpirq_flush_ack} = 3'b111;
      #1 check_val("commit_trap on alu fault", commit_trap, 1'b1);
      next_cycle();
    end
    end_test("alu_excp");

    // Masked interrupts must never trap
    repeat (40) begin
      clear_inputs();
      random_irq();
      {alu_excp_i_pc_vld, excpirq_flush_ack} = 2'b11;
      alu_excp_i_pc = $urandom;
      #1;
      if (!status_mie_r || amo_wait) check_val("commit_trap when masked", commit_trap, 1'b0);
      next_cycle();
    end
    end_test("irq");

    // All sources together with random back-pressure
    repeat (80) begin
      clear_inputs();
      random_irq();
      set_alu_fault($urandom_range(12, 0));
      {longp_excp_i_ld, longp_excp_i_st, longp_excp_i_buserr, longp_excp_i_insterr} = 4'($urandom);
      longp_excp_i_valid = ($urandom_range(2, 0) == 0);
      longp_excp_i_pc    = $urandom;
      alu_excp_i_valid   = $urandom_range(1, 0);
      alu_excp_i_pc_vld  = $urandom_range(1, 0);
      oitf_empty         = $urandom_range(1, 0);
      excpirq_flush_ack  = $urandom_range(1, 0);
      next_cycle();
    end
    end_test("priority");

    // Long-pipe bus and co-processor errors
    repeat (30) begin
      clear_inputs();
      k = $urandom_range(3, 0);
      case (k)
        0: {longp_excp_i_ld, longp_excp_i_buserr} = 2'b11;
        1: {longp_excp_i_st, longp_excp_i_buserr} = 2'b11;
        2: longp_excp_i_insterr = 1'b1;
        default: longp_excp_i_ld = 1'b1;
      endcase
      longp_excp_i_valid   = 1'b1;
      longp_excp_i_pc      = $urandom;
      longp_excp_i_badaddr = $urandom;
      excpirq_flush_ack    = $urandom_range(3, 0) != 0;
      next_cycle();
    end
    end_test("longp");

    // WFI commit, halt handshake, sleep and wakeup
    clear_inputs();
    {alu_excp_i_valid, alu_excp_i_wfi, cmt_ena} = 3'b111;
    next_cycle();
    clear_inputs();
    check_val("halt requests after wfi", {wfi_halt_ifu_req, wfi_halt_exu_req}, 2'b11);
    {wfi_halt_ifu_ack, wfi_halt_exu_ack} = 2'b11;
    n = 0;
    while (!core_wfi && n < 20) begin
      next_cycle();
      n++;
    end
    assert (core_wfi === 1'b1)
      else timed_out("core_wfi did not rise after both halts were acknowledged");
    sleeping = 1'b1;
    {wfi_halt_ifu_ack, wfi_halt_exu_ack} = 2'b00;
    next_cycle();
    // Enabled but globally masked interrupt still wakes the core
    {sft_irq_r, msie_r} = 2'b11;
    #1;
    check_val("core_wfi on wakeup", core_wfi, 1'b0);
    check_val("wfi_halt_ifu_req on wakeup", wfi_halt_ifu_req, 1'b0);
    n = 0;
    while (wfi_halt_exu_req && n < 5) begin
      next_cycle();
      n++;
    end
    assert (wfi_halt_exu_req === 1'b0)
      else timed_out("wfi_halt_exu_req stayed high after wakeup");
    sleeping = 1'b0;
    clear_inputs();
    next_cycle();
    end_test("wfi");

    chk_en = 1'b0;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- dv/excp_tb_clock.sv
/*
  Testbench clock and reset source, 10 ns period
  Reset is held high across the first two rising edges
*/
`timescale 1ns/1ns

module excp_tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after the second edge
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- verilog/exu_excp_top.sv
/*
  Commit-stage trap unit top: ALU and long-pipe exceptions, interrupts and WFI
*/
`timescale 1ns/1ns

module exu_excp_top import excp_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  // WFI handshake and status
  output logic  commit_trap,
  output logic  core_wfi,
  output logic  wfi_halt_ifu_req,
  output logic  wfi_halt_exu_req,
  input  logic  wfi_halt_ifu_ack,
  input  logic  wfi_halt_exu_ack,
  input  logic  amo_wait,

  // ALU commit path
  output logic  alu_excp_i_ready,
  input  logic  alu_excp_i_valid,
  input  logic  alu_excp_i_ld,
  input  logic  alu_excp_i_stamo,
  input  logic  alu_excp_i_misalgn,
  input  logic  alu_excp_i_buserr,
  input  logic  alu_excp_i_ecall,
  input  logic  alu_excp_i_ebreak,
  input  logic  alu_excp_i_wfi,
  input  logic  alu_excp_i_ifu_misalgn,
  input  logic  alu_excp_i_ifu_buserr,
  input  logic  alu_excp_i_ifu_ilegl,
  input  addr_t alu_excp_i_badaddr,
  input  pc_t   alu_excp_i_pc,
  input  xlen_t alu_excp_i_instr,
  input  logic  alu_excp_i_pc_vld,

  // Long-pipe path
  output logic  longp_excp_i_ready,
  input  logic  longp_excp_i_valid,
  input  logic  longp_excp_i_ld,
  input  logic  longp_excp_i_st,
  input  logic  longp_excp_i_buserr,
  input  logic  longp_excp_i_insterr,
  input  addr_t longp_excp_i_badaddr,
  input  pc_t   longp_excp_i_pc,

  // Flush to fetch
  input  logic  excpirq_flush_ack,
  output logic  excpirq_flush_req,
  output pc_t   excpirq_flush_add_op1,
  output pc_t   excpirq_flush_add_op2,

  // CSR side
  input  xlen_t csr_mtvec_r,
  input  logic  cmt_ena,
  output addr_t cmt_badaddr,
  output pc_t   cmt_epc,
  output xlen_t cmt_cause,
  output logic  cmt_badaddr_ena,
  output logic  cmt_epc_ena,
  output logic  cmt_cause_ena,
  output logic  cmt_status_ena,

  // Interrupt lines and enables
  input  logic  ext_irq_r,
  input  logic  sft_irq_r,
  input  logic  tmr_irq_r,
  input  logic  status_mie_r,
  input  logic  mtie_r,
  input  logic  msie_r,
  input  logic  meie_r,

  input  logic  oitf_empty,
  output logic  excp_active
);

  logic       alu_need_flush;
  exc_code_e  alu_cause;
  addr_t      alu_badaddr;
  logic       irq_req;
  logic       wfi_irq_req;
  irq_code_e  irq_cause;
  trap_kind_e trap_kind;
  logic       trap_taken;
  logic       wfi_cmt;

  // WFI retires through the normal commit
  assign wfi_cmt = alu_excp_i_wfi & cmt_ena;

  excp_alu_decode i_alu_decode (
    .alu_excp_i_misalgn     (alu_excp_i_misalgn),
    .alu_excp_i_buserr      (alu_excp_i_buserr),
    .alu_excp_i_ecall       (alu_excp_i_ecall),
    .alu_excp_i_ebreak      (alu_excp_i_ebreak),
    .alu_excp_i_ifu_misalgn (alu_excp_i_ifu_misalgn),
    .alu_excp_i_ifu_buserr  (alu_excp_i_ifu_buserr),
    .alu_excp_i_ifu_ilegl   (alu_excp_i_ifu_ilegl),
    .alu_excp_i_ld          (alu_excp_i_ld),
    .alu_excp_i_stamo       (alu_excp_i_stamo),
    .alu_excp_i_pc          (alu_excp_i_pc),
    .alu_excp_i_instr       (alu_excp_i_instr),
    .alu_excp_i_badaddr     (alu_excp_i_badaddr),
    .alu_need_flush         (alu_need_flush),
    .alu_cause              (alu_cause),
    .alu_badaddr            (alu_badaddr)
  );

  excp_irq_detect i_irq_detect (
    .ext_irq_r    (ext_irq_r),
    .sft_irq_r    (sft_irq_r),
    .tmr_irq_r    (tmr_irq_r),
    .meie_r       (meie_r),
    .msie_r       (msie_r),
    .mtie_r       (mtie_r),
    .status_mie_r (status_mie_r),
    .amo_wait     (amo_wait),
    .irq_req      (irq_req),
    .wfi_irq_req  (wfi_irq_req),
    .irq_cause    (irq_cause)
  );

  excp_wfi_ctrl i_wfi_ctrl (
    .clk              (clk),
    .reset            (reset),
    .wfi_cmt          (wfi_cmt),
    .wfi_irq_req      (wfi_irq_req),
    .irq_req          (irq_req),
    .wfi_halt_ifu_ack (wfi_halt_ifu_ack),
    .wfi_halt_exu_ack (wfi_halt_exu_ack),
    .wfi_halt_ifu_req (wfi_halt_ifu_req),
    .wfi_halt_exu_req (wfi_halt_exu_req),
    .core_wfi         (core_wfi),
    .excp_active      (excp_active)
  );

  // Arbiter sees the masked interrupt only
  excp_trap_arbiter i_trap_arbiter (
    .longp_excp_i_valid    (longp_excp_i_valid),
    .alu_excp_i_valid      (alu_excp_i_valid),
    .alu_excp_i_pc_vld     (alu_excp_i_pc_vld),
    .alu_need_flush        (alu_need_flush),
    .irq_req               (irq_req),
    .oitf_empty            (oitf_empty),
    .excpirq_flush_ack     (excpirq_flush_ack),
    .csr_mtvec_r           (csr_mtvec_r),
    .excpirq_flush_req     (excpirq_flush_req),
    .alu_excp_i_ready      (alu_excp_i_ready),
    .longp_excp_i_ready    (longp_excp_i_ready),
    .commit_trap           (commit_trap),
    .trap_taken            (trap_taken),
    .trap_kind             (trap_kind),
    .excpirq_flush_add_op1 (excpirq_flush_add_op1),
    .excpirq_flush_add_op2 (excpirq_flush_add_op2)
  );

  excp_csr_update i_csr_update (
    .trap_kind            (trap_kind),
    .trap_taken           (trap_taken),
    .alu_cause            (alu_cause),
    .irq_cause            (irq_cause),
    .longp_excp_i_ld      (longp_excp_i_ld),
    .longp_excp_i_st      (longp_excp_i_st),
    .longp_excp_i_buserr  (longp_excp_i_buserr),
    .longp_excp_i_insterr (longp_excp_i_insterr),
    .longp_excp_i_badaddr (longp_excp_i_badaddr),
    .alu_badaddr          (alu_badaddr),
    .longp_excp_i_pc      (longp_excp_i_pc),
    .alu_excp_i_pc        (alu_excp_i_pc),
    .cmt_cause            (cmt_cause),
    .cmt_epc              (cmt_epc),
    .cmt_badaddr          (cmt_badaddr),
    .cmt_cause_ena        (cmt_cause_ena),
    .cmt_epc_ena          (cmt_epc_ena),
    .cmt_status_ena       (cmt_status_ena),
    .cmt_badaddr_ena      (cmt_badaddr_ena)
  );

endmodule

//--- excp/excp_csr_update.sv
/*
  Builds mcause, mepc and mtval for the winning trap and the CSR write enables
*/
`timescale 1ns/1ns
`include "excp_config.svh"

module excp_csr_update import excp_pkg::*; (
  input  trap_kind_e trap_kind,
  input  logic       trap_taken,
  input  exc_code_e  alu_cause,
  input  irq_code_e  irq_cause,
  input  logic       longp_excp_i_ld,
  input  logic       longp_excp_i_st,
  input  logic       longp_excp_i_buserr,
  input  logic       longp_excp_i_insterr,
  input  addr_t      longp_excp_i_badaddr,
  input  addr_t      alu_badaddr,
  input  pc_t        longp_excp_i_pc,
  input  pc_t        alu_excp_i_pc,
  output xlen_t      cmt_cause,
  output pc_t        cmt_epc,
  output addr_t      cmt_badaddr,
  output logic       cmt_cause_ena,
  output logic       cmt_epc_ena,
  output logic       cmt_status_ena,
  output logic       cmt_badaddr_ena
);

  logic      longp_ldst_fault;
  exc_code_e longp_cause;

  // Bus error on a long-pipe load or store
  assign longp_ldst_fault = longp_excp_i_buserr & (longp_excp_i_ld | longp_excp_i_st);

  always_comb begin
    if (longp_excp_i_ld & longp_excp_i_buserr) begin
      longp_cause = ld_fault;
    end else if (longp_excp_i_st & longp_excp_i_buserr) begin
      longp_cause = st_fault;
    end else if (longp_excp_i_insterr) begin
      longp_cause = longp_insterr;
    end else begin
      longp_cause = reserved;
    end
  end

  //////////////////////////////////////////////////
  // Cause and trap value
  //////////////////////////////////////////////////
  always_comb begin
    cmt_cause   = '0;
    cmt_badaddr = alu_badaddr;
    case (trap_kind)
      trap_irq: begin
        cmt_cause[`EXCP_CAUSE_IRQ_BIT]     = 1'b1;
        cmt_cause[`EXCP_IRQ_CODE_W-1:0]    = irq_cause;
        cmt_badaddr                        = '0;
      end
      trap_longp: begin
        cmt_cause[`EXCP_EXC_CODE_W-1:0] = longp_cause;
        cmt_badaddr = longp_ldst_fault ? longp_excp_i_badaddr : '0;
      end
      default: cmt_cause[`EXCP_EXC_CODE_W-1:0] = alu_cause;
    endcase
  end

  // Long-pipe traps are imprecise and use the faulting pc itself
  assign cmt_epc = (trap_kind == trap_longp) ? longp_excp_i_pc : alu_excp_i_pc;

  // Every taken trap writes all four machine CSRs
  assign cmt_cause_ena   = trap_taken;
  assign cmt_epc_ena     = trap_taken;
  assign cmt_status_ena  = trap_taken;
  assign cmt_badaddr_ena = trap_taken;

endmodule

//--- excp/excp_trap_arbiter.sv
/*
  Fixed priority between long-pipe, interrupt and ALU traps
  Raises the flush to fetch and drives the source readies and taken strobes
*/
`timescale 1ns/1ns
`include "excp_config.svh"

module excp_trap_arbiter import excp_pkg::*; (
  input  logic       longp_excp_i_valid,
  input  logic       alu_excp_i_valid,
  input  logic       alu_excp_i_pc_vld,
  input  logic       alu_need_flush,
  input  logic       irq_req,
  input  logic       oitf_empty,
  input  logic       excpirq_flush_ack,
  input  xlen_t      csr_mtvec_r,
  output logic       excpirq_flush_req,
  output logic       alu_excp_i_ready,
  output logic       longp_excp_i_ready,
  output logic       commit_trap,
  output logic       trap_taken,
  output trap_kind_e trap_kind,
  output pc_t        excpirq_flush_add_op1,
  output pc_t        excpirq_flush_add_op2
);

  logic longp_flush_req;
  logic irq_flush_req;
  logic alu_flush_req;

  //////////////////////////////////////////////////
  // Per-source flush requests
  //////////////////////////////////////////////////
  // Long-pipe always asks, no pc_vld wait, so it can never stall
  assign longp_flush_req = longp_excp_i_valid;

  // Interrupt takes the next not-yet-committed pc as epc
  // so it needs a valid pc and no outstanding instructions
  assign irq_flush_req = irq_req & oitf_empty & alu_excp_i_pc_vld
                       & ~longp_flush_req;

  // ALU fault, lowest priority
  assign alu_flush_req = alu_excp_i_valid & alu_need_flush & oitf_empty
                       & ~irq_req
                       & ~longp_flush_req;

  assign excpirq_flush_req = longp_flush_req | irq_flush_req | alu_flush_req;

  //////////////////////////////////////////////////
  // Readies
  //////////////////////////////////////////////////
  assign longp_excp_i_ready = excpirq_flush_ack;

  // Faulting ALU commit waits for its own flush
  // A clean commit only yields to a higher request
  assign alu_excp_i_ready = alu_need_flush
                          ? (excpirq_flush_ack & oitf_empty & ~irq_req & ~longp_flush_req)
                          : (~irq_req & ~longp_flush_req);

  // Taken in the ack cycle
  assign trap_taken  = excpirq_flush_req & excpirq_flush_ack;
  assign commit_trap = trap_taken;

  // Winner for the CSR block
  always_comb begin
    if (longp_flush_req) begin
      trap_kind = trap_longp;
    end else if (irq_flush_req) begin
      trap_kind = trap_irq;
    end else if (alu_flush_req) begin
      trap_kind = trap_alu;
    end else begin
      trap_kind = trap_none;
    end
  end

  // Direct mode vector, fetch adds the two operands
  assign excpirq_flush_add_op1 = pc_t'(csr_mtvec_r);
  assign excpirq_flush_add_op2 = `EXCP_TRAP_VEC_OFS;

endmodule

//--- excp/excp_wfi_ctrl.sv
/*
  WFI sleep sequence: halt fetch and execute, sleep, wake on an enabled interrupt
  Also drives the activity level for the core clock gate
*/
`timescale 1ns/1ns

module excp_wfi_ctrl import excp_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic wfi_cmt,
  input  logic wfi_irq_req,
  input  logic irq_req,
  input  logic wfi_halt_ifu_ack,
  input  logic wfi_halt_exu_ack,
  output logic wfi_halt_ifu_req,
  output logic wfi_halt_exu_req,
  output logic core_wfi,
  output logic excp_active
);

  wfi_state_e state;
  wfi_state_e state_nxt;
  logic       halt_done;

  // Both halts handshaked in the same cycle
  assign halt_done = wfi_halt_ifu_req & wfi_halt_ifu_ack
                   & wfi_halt_exu_req & wfi_halt_exu_ack;

  always_comb begin
    state_nxt = state;
    // Wakeup clears and beats a simultaneous set
    if (wfi_irq_req) begin
      state_nxt = wfi_run;
    end else begin
      case (state)
        wfi_run:     if (wfi_cmt)   state_nxt = wfi_halting;
        wfi_halting: if (halt_done) state_nxt = wfi_sleep;
        default:     state_nxt = state;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wfi_run;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  // Fetch halt drops in the wake cycle so it never overlaps the trap flush
  assign wfi_halt_ifu_req = (state != wfi_run) & ~wfi_irq_req;
  // Execute halt drops a cycle later, keeps the ack path free of loops
  assign wfi_halt_exu_req = (state != wfi_run);
  assign core_wfi         = (state == wfi_sleep) & ~wfi_irq_req;

  // Clock gate wakeup, unmasked only while asleep
  assign excp_active = (state == wfi_sleep) ? wfi_irq_req : irq_req;

endmodule

//--- excp/excp_irq_detect.sv
/*
  Qualifies the machine interrupts and encodes the interrupt cause
*/
`timescale 1ns/1ns

module excp_irq_detect import excp_pkg::*; (
  input  logic      ext_irq_r,
  input  logic      sft_irq_r,
  input  logic      tmr_irq_r,
  input  logic      meie_r,
  input  logic      msie_r,
  input  logic      mtie_r,
  input  logic      status_mie_r,
  input  logic      amo_wait,
  output logic      irq_req,
  output logic      wfi_irq_req,
  output irq_code_e irq_cause
);

  logic ext_pend;
  logic sft_pend;
  logic tmr_pend;
  logic irq_raw;

  // Pending and individually enabled
  assign ext_pend = ext_irq_r & meie_r;
  assign sft_pend = sft_irq_r & msie_r;
  assign tmr_pend = tmr_irq_r & mtie_r;
  assign irq_raw  = ext_pend | sft_pend | tmr_pend;

  // Global enable, and hold off while an AMO is mid-sequence
  // Otherwise the trap would block the AMO commit forever
  assign irq_req = irq_raw & status_mie_r & ~amo_wait;

  // Wakeup ignores mie, a sleeping core has no AMO in flight
  assign wfi_irq_req = irq_raw;

  // Software over timer over external
  always_comb begin
    if (sft_pend) begin
      irq_cause = irq_soft;
    end else if (tmr_pend) begin
      irq_cause = irq_timer;
    end else if (ext_pend) begin
      irq_cause = irq_ext;
    end else begin
      irq_cause = irq_none;
    end
  end

endmodule

//--- excp/excp_alu_decode.sv
/*
  Decodes the ALU commit fault flags into a flush need, a cause and a bad address
  Pure combinational, feeds the arbiter and the CSR update block
*/
`timescale 1ns/1ns
`include "excp_config.svh"

module excp_alu_decode import excp_pkg::*; (
  input  logic      alu_excp_i_misalgn,
  input  logic      alu_excp_i_buserr,
  input  logic      alu_excp_i_ecall,
  input  logic      alu_excp_i_ebreak,
  input  logic      alu_excp_i_ifu_misalgn,
  input  logic      alu_excp_i_ifu_buserr,
  input  logic      alu_excp_i_ifu_ilegl,
  input  logic      alu_excp_i_ld,
  input  logic      alu_excp_i_stamo,
  input  pc_t       alu_excp_i_pc,
  input  xlen_t     alu_excp_i_instr,
  input  addr_t     alu_excp_i_badaddr,
  output logic      alu_need_flush,
  output exc_code_e alu_cause,
  output addr_t     alu_badaddr
);

  // Any fault flag asks for a flush
  // Ebreak always traps, there is no debug mode
  assign alu_need_flush = alu_excp_i_misalgn
                        | alu_excp_i_buserr
                        | alu_excp_i_ecall
                        | alu_excp_i_ebreak
                        | alu_excp_i_ifu_misalgn
                        | alu_excp_i_ifu_buserr
                        | alu_excp_i_ifu_ilegl;

  //////////////////////////////////////////////////
  // Cause encoding
  //////////////////////////////////////////////////
  // Fetch side first, then execute side
  always_comb begin
    if (alu_excp_i_ifu_misalgn) begin
      alu_cause = inst_misalgn;
    end else if (alu_excp_i_ifu_buserr) begin
      alu_cause = inst_fault;
    end else if (alu_excp_i_ifu_ilegl) begin
      alu_cause = illegal;
    end else if (alu_excp_i_ebreak) begin
      alu_cause = breakpoint;
    end else if (alu_excp_i_ld & alu_excp_i_misalgn) begin
      alu_cause = ld_misalgn;
    end else if (alu_excp_i_ld & alu_excp_i_buserr) begin
      alu_cause = ld_fault;
    end else if (alu_excp_i_stamo & alu_excp_i_misalgn) begin
      alu_cause = st_misalgn;
    end else if (alu_excp_i_stamo & alu_excp_i_buserr) begin
      alu_cause = st_fault;
    end else if (alu_excp_i_ecall) begin
      alu_cause = ecall_m;
    end else begin
      // Data fault without a load/store tag
      alu_cause = reserved;
    end
  end

  //////////////////////////////////////////////////
  // Bad address (mtval) selection
  //////////////////////////////////////////////////
  always_comb begin
    case (alu_cause)
      // AGU faults report the data address
      ld_misalgn, ld_fault, st_misalgn, st_fault: alu_badaddr = alu_excp_i_badaddr;
      // Fetch faults and ebreak report the pc
      inst_misalgn, inst_fault, breakpoint:       alu_badaddr = addr_t'(alu_excp_i_pc);
      // Illegal reports the instruction bits
      illegal: alu_badaddr = addr_t'(alu_excp_i_instr[`EXCP_INSTR_SIZE-1:0]);
      default: alu_badaddr = '0;
    endcase
  end

endmodule

//--- common/excp_pkg.sv
/*
  Types shared by the trap unit blocks: words, cause codes and FSM states
*/
`include "excp_config.svh"

package excp_pkg;

  // Word types
  typedef logic [`EXCP_XLEN-1:0]      xlen_t;
  typedef logic [`EXCP_PC_SIZE-1:0]   pc_t;
  typedef logic [`EXCP_ADDR_SIZE-1:0] addr_t;

  // Machine exception codes, M-mode only
  typedef enum logic [`EXCP_EXC_CODE_W-1:0] {
    inst_misalgn  = 5'd0,
    inst_fault    = 5'd1,
    illegal       = 5'd2,
    breakpoint    = 5'd3,
    ld_misalgn    = 5'd4,
    ld_fault      = 5'd5,
    st_misalgn    = 5'd6,
    st_fault      = 5'd7,
    ecall_m       = 5'd11,
    // Long-pipe co-processor error
    longp_insterr = 5'd16,
    reserved      = 5'd31
  } exc_code_e;

  // Machine interrupt codes
  typedef enum logic [`EXCP_IRQ_CODE_W-1:0] {
    irq_none  = 4'd0,
    irq_soft  = 4'd3,
    irq_timer = 4'd7,
    irq_ext   = 4'd11
  } irq_code_e;

  // Source that wins the flush
  typedef enum logic [1:0] {
    trap_none,
    trap_longp,
    trap_irq,
    trap_alu
  } trap_kind_e;

  // WFI sleep sequence
  typedef enum logic [1:0] {
    wfi_run,
    wfi_halting,
    wfi_sleep
  } wfi_state_e;

endpackage

//--- common/excp_config.svh
/*
  Widths, trap vector constants and cause-field positions for the trap unit
*/
`ifndef EXCP_CONFIG_SVH
`define EXCP_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define EXCP_XLEN        32
`define EXCP_PC_SIZE     32
`define EXCP_ADDR_SIZE   32
`define EXCP_INSTR_SIZE  32

//////////////////////////////////////////////////
// Cause word layout
//////////////////////////////////////////////////
// Interrupt flag of mcause
`define EXCP_CAUSE_IRQ_BIT  31
// Exception code field, low bits of mcause
`define EXCP_EXC_CODE_W     5
// Interrupt code field, low bits of mcause
`define EXCP_IRQ_CODE_W     4

// Offset added to mtvec for the flush target (direct mode only)
`define EXCP_TRAP_VEC_OFS   32'h0

`endif
